// File: hdl/audioPkg.sv
`default_nettype none

package audioPkg;

	// Voice bank dimensions
	localparam int numVoices = 8;
	localparam int addrWidth = 4;
	localparam int sampleWidth = 6;

	// Entries reserved per voice in the sample ROM
	localparam int numEntries = 1 << addrWidth;

	// Played length of each voice, never more than numEntries
	localparam int voiceDepth [numVoices] = '{16, 12, 10, 16, 8, 14, 6, 16};

	// Flat ROM, voice v starts at v * numEntries
	localparam int memDepth = numVoices * numEntries;
	localparam string sampleMemFile = "hdl/samples.mem";

	// Sum of all voices at full scale, and the count of active ones
	localparam int sumWidth = sampleWidth + $clog2(numVoices);
	localparam int countWidth = $clog2(numVoices + 1);

	typedef logic [numVoices-1:0] voiceMaskT;

	typedef logic [sampleWidth-1:0] sampleT;

	typedef logic [addrWidth-1:0] voiceAddrT;

	// State of one full set of players
	typedef struct packed {
		voiceMaskT playing;
		voiceAddrT [numVoices-1:0] addr;
	} voiceBankT;

endpackage

`default_nettype wire

// File: hdl/seqPkg.sv
`default_nettype none

package seqPkg;

	// Pattern length
	localparam int numSteps = 16;
	localparam int stepWidth = 4;

	// clock44 cycles per step
	localparam int stepPeriod = 32;
	localparam int timerWidth = $clog2(stepPeriod);

	typedef logic [stepWidth-1:0] stepT;

	typedef logic [timerWidth-1:0] timerT;

	// One voice mask per step
	typedef audioPkg::voiceMaskT [numSteps-1:0] patternT;

endpackage

`default_nettype wire

// File: hdl/samplePlayer.sv
`default_nettype none

module samplePlayer
	import audioPkg::*;
#(
	parameter int depth = 16
) (
	input logic clock44,
	input logic rstN,
	input logic trigger,
	output logic playing,
	output voiceAddrT addr
);

	logic atEnd;

	// Last entry of this voice
	assign atEnd = (addr == voiceAddrT'(depth - 1));

	always_ff @(posedge clock44) begin
		if (!rstN) begin
			playing <= 1'b0;
			addr <= '0;
		end else if (trigger) begin
			// A new hit restarts from the top, even mid sample
			playing <= 1'b1;
			addr <= '0;
		end else if (playing) begin
			if (atEnd) begin
				playing <= 1'b0;
				addr <= '0;
			end else begin
				addr <= addr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/padVoices.sv
`default_nettype none

module padVoices
	import audioPkg::*;
(
	input logic clock44,
	input logic rstN,
	input voiceMaskT pads,
	output voiceMaskT padHits,
	output voiceBankT padBank
);

	voiceMaskT padsPrev;
	wire voiceMaskT livePlaying;
	wire voiceAddrT [numVoices-1:0] liveAddr;

	// Pad levels seen on the last edge
	always_ff @(posedge clock44) begin
		if (!rstN) begin
			padsPrev <= '0;
		end else begin
			padsPrev <= pads;
		end
	end

	// Rising pad only, so a held pad hits once
	assign padHits = pads & ~padsPrev;

	// One live player per voice
	for (genvar i = 0; i < numVoices; i++) begin : gLive
		samplePlayer #(
			.depth(voiceDepth[i])
		) playerInst (
			.clock44(clock44),
			.rstN(rstN),
			.trigger(padHits[i]),
			.playing(livePlaying[i]),
			.addr(liveAddr[i])
		);
	end

	assign padBank = '{playing: livePlaying, addr: liveAddr};

endmodule

`default_nettype wire

// File: hdl/patternSequencer.sv
`default_nettype none

module patternSequencer
	import audioPkg::*, seqPkg::*;
(
	input logic clock44,
	input logic rstN,
	input voiceMaskT padHits,
	input logic recordMode,
	input logic playEn,
	input logic clearPattern,
	output voiceBankT seqBank
);

	timerT stepTimer;
	stepT step;
	patternT pattern;
	voiceMaskT seqTrig;
	logic stepStart;
	wire voiceMaskT seqPlaying;
	wire voiceAddrT [numVoices-1:0] seqAddr;

	// Step timer and index
	// both sit at zero while stopped, so step 0 fires on the first play edge
	always_ff @(posedge clock44) begin
		if (!rstN) begin
			stepTimer <= '0;
			step <= '0;
		end else if (!playEn) begin
			stepTimer <= '0;
			step <= '0;
		end else if (stepTimer == timerT'(stepPeriod - 1)) begin
			stepTimer <= '0;
			if (step == stepT'(numSteps - 1)) begin
				step <= '0;
			end else begin
				step <= step + 1'b1;
			end
		end else begin
			stepTimer <= stepTimer + 1'b1;
		end
	end

	// Pattern memory
	// Clear beats a hit recorded on the same edge
	always_ff @(posedge clock44) begin
		if (!rstN) begin
			pattern <= '0;
		end else if (clearPattern) begin
			pattern <= '0;
		end else if (recordMode) begin
			pattern[step] <= pattern[step] | padHits;
		end
	end

	// First cycle of a step while playing
	assign stepStart = playEn && (stepTimer == '0);

	// Stored voices of the current step
	assign seqTrig = stepStart ? pattern[step] : '0;

	// One sequencer player per voice
	for (genvar i = 0; i < numVoices; i++) begin : gSeq
		samplePlayer #(
			.depth(voiceDepth[i])
		) playerInst (
			.clock44(clock44),
			.rstN(rstN),
			.trigger(seqTrig[i]),
			.playing(seqPlaying[i]),
			.addr(seqAddr[i])
		);
	end

	assign seqBank = '{playing: seqPlaying, addr: seqAddr};

endmodule

`default_nettype wire

// File: hdl/voiceMixer.sv
`default_nettype none

module voiceMixer
	import audioPkg::*;
(
	input logic clock44,
	input logic rstN,
	input voiceBankT padBank,
	input voiceBankT seqBank,
	output sampleT mixOut,
	output voiceMaskT voiceActive
);

	// Sample ROM, numEntries words per voice
	sampleT sampleMem [memDepth];

	voiceAddrT [numVoices-1:0] addrS1;
	voiceMaskT activeS1;
	sampleT [numVoices-1:0] sampleS2;
	voiceMaskT activeS2;
	logic [sumWidth-1:0] sampleSum;
	logic [countWidth-1:0] activeCount;

	initial begin
		$readmemh(sampleMemFile, sampleMem);
	end

	// First stage picks the address source
	// the live player owns its voice while it plays
	always_ff @(posedge clock44) begin
		for (int i = 0; i < numVoices; i++) begin
			if (padBank.playing[i]) begin
				addrS1[i] <= padBank.addr[i];
			end else begin
				addrS1[i] <= seqBank.addr[i];
			end
		end
	end

	always_ff @(posedge clock44) begin
		if (!rstN) begin
			activeS1 <= '0;
		end else begin
			activeS1 <= padBank.playing | seqBank.playing;
		end
	end

	// ROM read, silent voices read as zero
	always_ff @(posedge clock44) begin
		for (int i = 0; i < numVoices; i++) begin
			if (activeS1[i]) begin
				sampleS2[i] <= sampleMem[i * numEntries + int'(addrS1[i])];
			end else begin
				sampleS2[i] <= '0;
			end
		end
	end

	always_ff @(posedge clock44) begin
		if (!rstN) begin
			activeS2 <= '0;
		end else begin
			activeS2 <= activeS1;
		end
	end

	// Sum and count of the voices in the second stage
	always_comb begin
		sampleSum = '0;
		activeCount = '0;
		for (int i = 0; i < numVoices; i++) begin
			if (activeS2[i]) begin
				sampleSum = sampleSum + sumWidth'(sampleS2[i]);
				activeCount = activeCount + 1'b1;
			end
		end
	end

	// Average rounds down, and fits a sample since no input exceeds one
	always_ff @(posedge clock44) begin
		if (!rstN) begin
			mixOut <= '0;
			voiceActive <= '0;
		end else begin
			voiceActive <= activeS2;
			if (activeCount == '0) begin
				mixOut <= '0;
			end else begin
				mixOut <= sampleT'(sampleSum / sumWidth'(activeCount));
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/drumMachine.sv
`default_nettype none

module drumMachine
	import audioPkg::*;
(
	input logic clock44,
	input logic rstN,
	input voiceMaskT pads,
	input logic recordMode,
	input logic playEn,
	input logic clearPattern,
	output sampleT mixOut,
	output voiceMaskT voiceActive
);

	voiceMaskT padHits;
	voiceBankT padBank;
	voiceBankT seqBank;

	// Live pad playback
	padVoices padVoicesInst (
		.clock44(clock44),
		.rstN(rstN),
		.pads(pads),
		.padHits(padHits),
		.padBank(padBank)
	);

	// Step sequencer, records the same pad hits
	patternSequencer patternSequencerInst (
		.clock44(clock44),
		.rstN(rstN),
		.padHits(padHits),
		.recordMode(recordMode),
		.playEn(playEn),
		.clearPattern(clearPattern),
		.seqBank(seqBank)
	);

	// Both banks meet here, three cycles to the output
	voiceMixer voiceMixerInst (
		.clock44(clock44),
		.rstN(rstN),
		.padBank(padBank),
		.seqBank(seqBank),
		.mixOut(mixOut),
		.voiceActive(voiceActive)
	);

endmodule

`default_nettype wire

// File: dv/drumMachineTb.sv
`default_nettype none

module drumMachineTb
	import audioPkg::*, seqPkg::*;
();

	localparam int resetCycles = 4;
	localparam int driveDelay = 10;
	localparam int timeoutMargin = 100;
	localparam logic [31:0] lfsrSeed = 32'hb753;

	// One row of the stimulus table
	typedef struct packed {
		voiceMaskT pads;
		logic randPads;
		logic recordMode;
		logic playEn;
		logic clearPattern;
		logic [15:0] cycles;
	} stimRowT;

	logic clock44;
	logic rstN;
	voiceMaskT pads;
	logic recordMode;
	logic playEn;
	logic clearPattern;
	sampleT mixOut;
	voiceMaskT voiceActive;

	stimRowT rowQ[$];
	string nameQ[$];
	logic [31:0] lfsrState;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int timeoutLimit = 0;

	// Reference model state, a position of -1 means idle
	sampleT refMem [memDepth];
	voiceMaskT padsPrevRef;
	int livePos [numVoices];
	int seqPos [numVoices];
	int stepTimerRef;
	int stepRef;
	voiceMaskT patternRef [numSteps];
	int s1Addr [numVoices];
	voiceMaskT s1Active;
	int s2Sample [numVoices];
	voiceMaskT s2Active;
	int expMix;
	voiceMaskT expActive;

	drumMachine drumMachine_inst (
		.clock44(clock44),
		.rstN(rstN),
		.pads(pads),
		.recordMode(recordMode),
		.playEn(playEn),
		.clearPattern(clearPattern),
		.mixOut(mixOut),
		.voiceActive(voiceActive)
	);

	always #50 clock44 = ~clock44;

	// Run length guard
	always @(posedge clock44) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("Timeout after %0d cycles, the test table never finished", cycleCount);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic drawPadMask(output voiceMaskT mask);
		for (int b = 0; b < numVoices; b++) begin
			lfsrState = lfsrNext(lfsrState);
			mask[b] = lfsrState[0];
		end
	endtask

	task automatic addRow(input string name, input voiceMaskT padMask, input bit rnd,
			input bit rec, input bit play, input bit clr, input int cycles);
		nameQ.push_back(name);
		rowQ.push_back('{pads: padMask, randPads: rnd, recordMode: rec, playEn: play,
			clearPattern: clr, cycles: 16'(cycles)});
	endtask

	task automatic compareValue(input string testName, input string signalName,
			input logic [31:0] expected, input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h",
				testName, signalName, expected, actual);
		end
	endtask

	// Next position of one player after an edge
	function automatic int nextPos(input int pos, input bit trig, input int depth);
		if (trig) begin
			return 0;
		end
		if (pos < 0 || pos == depth - 1) begin
			return -1;
		end
		return pos + 1;
	endfunction

	task automatic modelReset();
		padsPrevRef = '0;
		stepTimerRef = 0;
		stepRef = 0;
		s1Active = '0;
		s2Active = '0;
		expMix = 0;
		expActive = '0;
		for (int v = 0; v < numVoices; v++) begin
			livePos[v] = -1;
			seqPos[v] = -1;
			s1Addr[v] = 0;
			s2Sample[v] = 0;
		end
		for (int s = 0; s < numSteps; s++) begin
			patternRef[s] = '0;
		end
	endtask

	// One clock edge of the whole machine, later stages first
	task automatic modelStep();
		voiceMaskT hits;
		voiceMaskT seqFire;
		int sum;
		int count;
		sum = 0;
		count = 0;
		for (int v = 0; v < numVoices; v++) begin
			if (s2Active[v]) begin
				sum += s2Sample[v];
				count++;
			end
		end
		expMix = (count == 0) ? 0 : sum / count;
		expActive = s2Active;
		for (int v = 0; v < numVoices; v++) begin
			s2Sample[v] = s1Active[v] ? int'(refMem[v * numEntries + s1Addr[v]]) : 0;
		end
		s2Active = s1Active;
		// Live player owns the voice while it plays
		for (int v = 0; v < numVoices; v++) begin
			s1Active[v] = (livePos[v] >= 0) || (seqPos[v] >= 0);
			s1Addr[v] = (livePos[v] >= 0) ? livePos[v] : seqPos[v];
		end
		hits = pads & ~padsPrevRef;
		seqFire = (playEn && stepTimerRef == 0) ? patternRef[stepRef] : '0;
		if (clearPattern) begin
			for (int s = 0; s < numSteps; s++) begin
				patternRef[s] = '0;
			end
		end else if (recordMode) begin
			patternRef[stepRef] |= hits;
		end
		if (!playEn) begin
			stepTimerRef = 0;
			stepRef = 0;
		end else if (stepTimerRef == stepPeriod - 1) begin
			stepTimerRef = 0;
			stepRef = (stepRef + 1) % numSteps;
		end else begin
			stepTimerRef++;
		end
		padsPrevRef = pads;
		for (int v = 0; v < numVoices; v++) begin
			livePos[v] = nextPos(livePos[v], hits[v], voiceDepth[v]);
			seqPos[v] = nextPos(seqPos[v], seqFire[v], voiceDepth[v]);
		end
	endtask

	task automatic loadTable();
		// name, pads, random pads, record, play, clear, cycles
		addRow("idle", 8'h00, 0, 0, 0, 0, 40);
		addRow("hitV0", 8'h01, 0, 0, 0, 0, 1);
		addRow("drainV0", 8'h00, 0, 0, 0, 0, 24);
		addRow("hitV6", 8'h40, 0, 0, 0, 0, 1);
		addRow("drainV6", 8'h00, 0, 0, 0, 0, 14);
		addRow("hitMulti", 8'h96, 0, 0, 0, 0, 1);
		addRow("drainMulti", 8'h00, 0, 0, 0, 0, 24);
		addRow("rand1", 8'h00, 1, 0, 0, 0, 1);
		addRow("drainRand1", 8'h00, 0, 0, 0, 0, 24);
		addRow("rand2", 8'h00, 1, 0, 0, 0, 2);
		addRow("drainRand2", 8'h00, 0, 0, 0, 0, 24);
		addRow("rand3", 8'h00, 1, 0, 0, 0, 1);
		addRow("drainRand3", 8'h00, 0, 0, 0, 0, 24);
		addRow("holdV3", 8'h08, 0, 0, 0, 0, 30);
		addRow("releaseV3", 8'h00, 0, 0, 0, 0, 2);
		addRow("pressV3", 8'h08, 0, 0, 0, 0, 6);
		addRow("releaseAgain", 8'h00, 0, 0, 0, 0, 1);
		addRow("restartV3", 8'h08, 0, 0, 0, 0, 1);
		addRow("drainV3", 8'h00, 0, 0, 0, 0, 24);
		addRow("recV0", 8'h01, 0, 1, 0, 0, 1);
		addRow("recIdle", 8'h00, 0, 1, 0, 0, 1);
		// Step 0 fires on the first edge with play on
		addRow("playStart", 8'h00, 0, 0, 1, 0, 40);
		addRow("recV5", 8'h20, 0, 1, 1, 0, 1);
		addRow("playLoop", 8'h00, 0, 0, 1, 0, 472);
		addRow("padOverSeq", 8'h01, 0, 0, 1, 0, 4);
		addRow("playOn", 8'h00, 0, 0, 1, 0, 507);
		addRow("playWrap", 8'h00, 0, 0, 1, 0, 3);
		addRow("clearMid", 8'h00, 0, 0, 1, 1, 1);
		addRow("afterClear", 8'h00, 0, 0, 1, 0, 600);
		addRow("stopPlay", 8'h00, 0, 0, 0, 0, 24);
		addRow("clearAndHit", 8'h04, 0, 1, 0, 1, 1);
		addRow("checkCleared", 8'h00, 0, 0, 1, 0, 540);
	endtask

	initial begin
		stimRowT row;
		int rowStart;
		int totalCycles;
		clock44 = 1'b0;
		rstN = 1'b0;
		pads = '0;
		recordMode = 1'b0;
		playEn = 1'b0;
		clearPattern = 1'b0;
		lfsrState = lfsrSeed;
		loadTable();
		totalCycles = 0;
		foreach (rowQ[i]) begin
			totalCycles += int'(rowQ[i].cycles);
		end
		timeoutLimit = resetCycles + totalCycles + timeoutMargin;
		$readmemh(sampleMemFile, refMem);
		modelReset();
		repeat (resetCycles) @(posedge clock44);
		#driveDelay;
		rstN = 1'b1;
		foreach (rowQ[r]) begin
			row = rowQ[r];
			rowStart = errorCount;
			if (row.randPads) begin
				drawPadMask(pads);
			end else begin
				pads = row.pads;
			end
			recordMode = row.recordMode;
			playEn = row.playEn;
			clearPattern = row.clearPattern;
			for (int c = 0; c < int'(row.cycles); c++) begin
				@(posedge clock44);
				modelStep();
				#driveDelay;
				compareValue(nameQ[r], "mixOut", expMix, 32'(mixOut));
				compareValue(nameQ[r], "voiceActive", 32'(expActive), 32'(voiceActive));
			end
			$display("%-14s pads 0x%02h, %0d cycles, %0d mismatches", nameQ[r], pads,
				row.cycles, errorCount - rowStart);
		end
		$display("Rows %0d, checks %0d, errors %0d", rowQ.size(), checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/samples.mem
// One line per voice 0 to 7, sixteen 6-bit samples in hex for addresses 0 to 15
01 04 07 0A 0D 10 13 16 19 1C 1F 22 25 28 2B 2E
3F 3A 35 30 2B 26 21 1C 17 12 0D 08 03 3E 39 34
20 28 30 38 00 08 10 18 1F 17 0F 07 3F 37 2F 27
05 0B 11 17 1D 23 29 2F 35 3B 01 07 0D 13 19 1F
33 2C 25 1E 17 10 09 02 3B 34 2D 26 1F 18 11 0A
0E 1C 2A 38 06 14 22 30 3E 0C 1A 28 36 04 12 20
3C 02 38 06 34 0A 30 0E 2C 12 28 16 24 1A 20 1E
11 22 33 04 15 26 37 08 19 2A 3B 0C 1D 2E 3F 10

// File: flist.f
hdl/audioPkg.sv
hdl/seqPkg.sv
hdl/samplePlayer.sv
hdl/padVoices.sv
hdl/patternSequencer.sv
hdl/voiceMixer.sv
hdl/drumMachine.sv
dv/drumMachineTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the drum machine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module drumMachineTb \
	-f flist.f \
	--Mdir obj_dir -o drumMachineSim

./obj_dir/drumMachineSim > sim.log 2>&1
cat sim.log

if grep -qF "*** FAILED ***" sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi

echo "Simulation log clean"
exit 0
